/* tb.f */
verilog/arcade_pkg.sv
verilog/shell_cfg_if.sv
verilog/wb_config_regs.sv
verilog/control_mapper.sv
verilog/audio_mixer_dac.sv
verilog/video_output.sv
verilog/arcade_shell_top.sv
sim/tb_arcade_shell.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the failure message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_arcade_shell \
	-f tb.f -o tb_arcade_shell > build.log 2>&1 \
	&& ./obj_dir/tb_arcade_shell > sim.log 2>&1 \
	|| { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

/* sim/tb_arcade_shell.sv */
module tb_arcade_shell;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] CORE_ID_VAL = 32'h53484c31;
	localparam int NUM_FIXED   = 9;
	localparam int NUM_ENTRIES = 13;
	// Each entry takes about 2060 cycles of 4 ns, the rest is margin
	localparam int WATCHDOG_NS = NUM_ENTRIES * 2100 * 4 + 2000;

	typedef struct packed {
		logic [5:0] settings;
		logic [9:0] kbjoy;
		logic [7:0] joy0;
		logic [7:0] joy1;
		logic [7:0] snd_a;
		logic [7:0] snd_b;
		logic [2:0] col_r;
		logic [2:0] col_g;
		logic [2:0] col_b;
		logic       hs;
		logic       vs;
		logic       hblank;
		logic       vblank;
	} stim_t;

	logic clk_sys = 1'b0;
	logic rst_n;
	logic wb_cyc, wb_stb, wb_we, wb_ack;
	arcade_pkg::wb_adr_t     wb_adr;
	arcade_pkg::wb_data_t    wb_dat_w, wb_dat_r;
	arcade_pkg::kbjoy_t      kbjoy;
	arcade_pkg::joy_t        joystick_0, joystick_1;
	arcade_pkg::sample_t     audio_a, audio_b;
	arcade_pkg::core_color_t r, g, b;
	logic hs, vs, hblank, vblank, core_reset, audio_out, vga_hs, vga_vs;
	arcade_pkg::player_ctl_t p1_ctl, p2_ctl;
	arcade_pkg::vga_color_t  vga_r, vga_g, vga_b;

	int          errors = 0;
	int          checks = 0;
	logic [31:0] lfsr_q = 32'h6f027b5a;
	stim_t       stim [NUM_ENTRIES];

	arcade_shell_top #(.CORE_ID(CORE_ID_VAL)) u_dut (.*);

	always #2 clk_sys = ~clk_sys;

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("test failed");
		$finish;
	end

	// ==============================
	// Helpers
	// ==============================
	task automatic check_equal(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// One classic cycle, with stb dropped on the edge that shows the ack
	task automatic bus_cycle(input logic we, input arcade_pkg::wb_adr_t adr,
			input arcade_pkg::wb_data_t wdata, output arcade_pkg::wb_data_t rdata);
		int waited;
		waited   = 0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		do begin
			@(posedge clk_sys);
			#1;
			waited++;
		end while (!wb_ack && waited < 8);
		rdata = wb_dat_r;
		checks++;
		assert (wb_ack) else begin
			errors++;
			$display("Bus access to address %0d was never acknowledged", adr);
		end
		// Request seen on the first edge, ack shown after the second
		check_equal("acknowledge latency in cycles", waited, 2);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(posedge clk_sys);
		#1;
		check_equal("wb_ack one cycle after the acknowledge", wb_ack, 0);
	endtask

	task automatic wb_write(input arcade_pkg::wb_adr_t adr, input arcade_pkg::wb_data_t data);
		arcade_pkg::wb_data_t ignored;
		bus_cycle(1'b1, adr, data, ignored);
	endtask

	task automatic wb_read(input arcade_pkg::wb_adr_t adr, output arcade_pkg::wb_data_t data);
		bus_cycle(1'b0, adr, '0, data);
	endtask

	task automatic drive_inputs(input stim_t st);
		kbjoy      = st.kbjoy;
		joystick_0 = st.joy0;
		joystick_1 = st.joy1;
		audio_a    = st.snd_a;
		audio_b    = st.snd_b;
		r          = st.col_r;
		g          = st.col_g;
		b          = st.col_b;
		hs         = st.hs;
		vs         = st.vs;
		hblank     = st.hblank;
		vblank     = st.vblank;
	endtask

	task automatic count_audio(output int ones);
		ones = 0;
		repeat (2048) begin
			@(posedge clk_sys);
			#1;
			if (audio_out) begin
				ones++;
			end
		end
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic stim_t random_entry();
		stim_t st;
		st.settings = 6'(random_bits(6));
		st.kbjoy    = 10'(random_bits(10));
		st.joy0     = 8'(random_bits(8));
		st.joy1     = 8'(random_bits(8));
		st.snd_a    = 8'(random_bits(8));
		st.snd_b    = 8'(random_bits(8));
		st.col_r    = 3'(random_bits(3));
		st.col_g    = 3'(random_bits(3));
		st.col_b    = 3'(random_bits(3));
		st.hs       = 1'(random_bits(1));
		st.vs       = 1'(random_bits(1));
		st.hblank   = 1'(random_bits(1));
		st.vblank   = 1'(random_bits(1));
		return st;
	endfunction

	// Returns {player 2, player 1}, each as {0, coin, start, fire, up, down, left, right}
	function automatic logic [15:0] expected_players(input stim_t st);
		logic rt, lf, dn, up, fire;
		logic [7:0] p1, p2;
		rt   = st.kbjoy[4] | st.joy0[0] | st.joy1[0];
		lf   = st.kbjoy[5] | st.joy0[1] | st.joy1[1];
		dn   = st.kbjoy[6] | st.joy0[2] | st.joy1[2];
		up   = st.kbjoy[7] | st.joy0[3] | st.joy1[3];
		fire = st.kbjoy[0] | st.joy0[4] | st.joy1[4];
		if (st.settings[2]) begin
			{up, dn, lf, rt} = {rt, lf, dn, up};
		end
		p1 = {1'b0, st.kbjoy[3], st.kbjoy[1], fire, 2'b00, lf, rt};
		p2 = {2'b00, st.kbjoy[2], fire, up, dn, 2'b00};
		return {p2, p1};
	endfunction

	function automatic int expected_color(input logic [2:0] v, input stim_t st, input logic odd);
		int w;
		w = v * 9;
		if (st.hblank || st.vblank) begin
			w = 0;
		end else if (odd && st.settings[4:3] == 2'd2) begin
			w = w - w / 4;
		end else if (odd && st.settings[4:3] == 2'd3) begin
			w = w / 2;
		end
		return w;
	endfunction

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		stim_t                st;
		arcade_pkg::wb_data_t rd;
		int                   ones;
		int                   exp_mix;
		int                   exp_r, exp_g, exp_b;
		logic [15:0]          exp_players;
		logic                 line_odd;
		logic                 hs_prev;

		rst_n    = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		drive_inputs('0);
		line_odd = 1'b0;
		hs_prev  = 1'b0;

		// settings, kbjoy, joy0, joy1, a, b, r, g, b, hs, vs, hblank, vblank
		stim[0] = '{6'h00, 10'h019, 8'h00, 8'h00, 8'd17, 8'd3, 3'd7, 3'd5, 3'd2, 1'b0, 1'b0, 1'b0, 1'b0};
		stim[1] = '{6'h01, 10'h0a2, 8'h01, 8'h00, 8'd255, 8'd255, 3'd1, 3'd2, 3'd3, 1'b1, 1'b0, 1'b0, 1'b0};
		stim[2] = '{6'h10, 10'h000, 8'h04, 8'h10, 8'd0, 8'd0, 3'd7, 3'd7, 3'd7, 1'b0, 1'b1, 1'b0, 1'b0};
		stim[3] = '{6'h18, 10'h004, 8'h00, 8'h08, 8'd100, 8'd20, 3'd6, 3'd4, 3'd1, 1'b1, 1'b1, 1'b0, 1'b0};
		stim[4] = '{6'h14, 10'h040, 8'h01, 8'h00, 8'd1, 8'd0, 3'd5, 3'd3, 3'd7, 1'b0, 1'b0, 1'b0, 1'b0};
		stim[5] = '{6'h08, 10'h008, 8'h00, 8'h02, 8'd0, 8'd1, 3'd4, 3'd4, 3'd4, 1'b1, 1'b0, 1'b0, 1'b0};
		stim[6] = '{6'h0c, 10'h080, 8'h0c, 8'h00, 8'd200, 8'd50, 3'd7, 3'd1, 3'd6, 1'b0, 1'b0, 1'b0, 1'b0};
		stim[7] = '{6'h38, 10'h001, 8'h00, 8'h00, 8'd250, 8'd255, 3'd3, 3'd3, 3'd3, 1'b0, 1'b0, 1'b0, 1'b0};
		stim[8] = '{6'h1c, 10'h030, 8'h0f, 8'h1f, 8'd9, 8'd9, 3'd7, 3'd7, 3'd7, 1'b0, 1'b0, 1'b1, 1'b0};
		for (int i = NUM_FIXED; i < NUM_ENTRIES; i++) begin
			stim[i] = random_entry();
		end

		repeat (16) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;
		check_equal("core_reset after reset", core_reset, 0);

		// Register map, including writes to the read-only words
		wb_read(arcade_pkg::ADR_CORE_ID, rd);
		check_equal("core identifier", rd, CORE_ID_VAL);
		wb_write(arcade_pkg::ADR_SETTINGS, 32'h0000002a);
		wb_write(arcade_pkg::ADR_CORE_ID, 32'hffffffff);
		wb_write(arcade_pkg::ADR_PLAYERS, 32'h00000015);
		wb_read(arcade_pkg::ADR_CORE_ID, rd);
		check_equal("core identifier after a write", rd, CORE_ID_VAL);
		wb_read(arcade_pkg::ADR_SETTINGS, rd);
		check_equal("settings after read-only writes", rd, 32'h0000002a);

		for (int i = 0; i < NUM_ENTRIES; i++) begin
			st = stim[i];
			wb_write(arcade_pkg::ADR_SETTINGS, 32'(st.settings));
			wb_read(arcade_pkg::ADR_SETTINGS, rd);
			check_equal("settings readback", rd, 32'(st.settings));
			check_equal("core_reset", core_reset, st.settings[0]);

			drive_inputs(st);
			exp_players = expected_players(st);
			// The word registered on this edge still uses the old line parity
			exp_r = expected_color(st.col_r, st, line_odd);
			exp_g = expected_color(st.col_g, st, line_odd);
			exp_b = expected_color(st.col_b, st, line_odd);
			if (st.hs && !hs_prev) begin
				line_odd = !line_odd;
			end
			hs_prev = st.hs;
			@(posedge clk_sys);
			#1;
			check_equal("p1_ctl", p1_ctl, exp_players[7:0]);
			check_equal("p2_ctl", p2_ctl, exp_players[15:8]);
			check_equal("vga_r", vga_r, exp_r);
			check_equal("vga_g", vga_g, exp_g);
			check_equal("vga_b", vga_b, exp_b);
			check_equal("vga_hs", vga_hs, st.hs);
			check_equal("vga_vs", vga_vs, st.vs);

			wb_read(arcade_pkg::ADR_PLAYERS, rd);
			check_equal("players register", rd, {16'h0000, exp_players});

			exp_mix = st.settings[5] ? 0 : 4 * st.snd_b + st.snd_a;
			count_audio(ones);
			checks++;
			assert (st.settings[5] ? ones == 0 : (ones >= exp_mix - 1 && ones <= exp_mix + 1))
			else begin
				errors++;
				$display("Error at %0t ns: audio_out high %0d times in 2048 cycles, expected %0d",
					$time, ones, exp_mix);
			end
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* verilog/arcade_shell_top.sv */
module arcade_shell_top #(
	parameter arcade_pkg::wb_data_t CORE_ID = 32'h424c4b48
) (
	input  logic                    clk_sys,
	input  logic                    rst_n,

	// Wishbone classic slave
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  arcade_pkg::wb_adr_t     wb_adr,
	input  arcade_pkg::wb_data_t    wb_dat_w,
	output arcade_pkg::wb_data_t    wb_dat_r,
	output logic                    wb_ack,

	// Controls from the keyboard decoder and the joysticks
	input  arcade_pkg::kbjoy_t      kbjoy,
	input  arcade_pkg::joy_t        joystick_0,
	input  arcade_pkg::joy_t        joystick_1,

	// Game core side
	input  arcade_pkg::sample_t     audio_a,
	input  arcade_pkg::sample_t     audio_b,
	input  arcade_pkg::core_color_t r,
	input  arcade_pkg::core_color_t g,
	input  arcade_pkg::core_color_t b,
	input  logic                    hs,
	input  logic                    vs,
	input  logic                    hblank,
	input  logic                    vblank,
	output logic                    core_reset,
	output arcade_pkg::player_ctl_t p1_ctl,
	output arcade_pkg::player_ctl_t p2_ctl,

	// Board outputs
	output logic                    audio_out,
	output arcade_pkg::vga_color_t  vga_r,
	output arcade_pkg::vga_color_t  vga_g,
	output arcade_pkg::vga_color_t  vga_b,
	output logic                    vga_hs,
	output logic                    vga_vs
);

	shell_cfg_if cfg_bus ();

	assign core_reset = cfg_bus.core_reset;

	wb_config_regs #(
		.CORE_ID (CORE_ID)
	) u_regs (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.p1_ctl   (p1_ctl),
		.p2_ctl   (p2_ctl),
		.cfg      (cfg_bus)
	);

	control_mapper u_mapper (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.kbjoy      (kbjoy),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.cfg        (cfg_bus),
		.p1_ctl     (p1_ctl),
		.p2_ctl     (p2_ctl)
	);

	audio_mixer_dac u_audio (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.audio_a   (audio_a),
		.audio_b   (audio_b),
		.cfg       (cfg_bus),
		.audio_out (audio_out)
	);

	video_output u_video (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.r       (r),
		.g       (g),
		.b       (b),
		.hs      (hs),
		.vs      (vs),
		.hblank  (hblank),
		.vblank  (vblank),
		.cfg     (cfg_bus),
		.vga_r   (vga_r),
		.vga_g   (vga_g),
		.vga_b   (vga_b),
		.vga_hs  (vga_hs),
		.vga_vs  (vga_vs)
	);

endmodule

/* verilog/video_output.sv */
module video_output (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  arcade_pkg::core_color_t r,
	input  arcade_pkg::core_color_t g,
	input  arcade_pkg::core_color_t b,
	input  logic                    hs,
	input  logic                    vs,
	input  logic                    hblank,
	input  logic                    vblank,
	shell_cfg_if.dp                 cfg,
	output arcade_pkg::vga_color_t  vga_r,
	output arcade_pkg::vga_color_t  vga_g,
	output arcade_pkg::vga_color_t  vga_b,
	output logic                    vga_hs,
	output logic                    vga_vs
);

	logic blank;
	logic line_odd_q;

	// Blank, widen to 6 bits, then dim on odd lines
	function automatic arcade_pkg::vga_color_t shade(
		input arcade_pkg::core_color_t v,
		input logic                    blk,
		input logic                    odd,
		input arcade_pkg::scan_mode_t  mode
	);
		arcade_pkg::vga_color_t w;
		w = {v, v};
		if (blk) begin
			w = '0;
		end else if (odd && mode == arcade_pkg::scan_dim25) begin
			w = w - (w >> 2);
		end else if (odd && mode == arcade_pkg::scan_dim50) begin
			w = w >> 1;
		end
		return w;
	endfunction

	assign blank = hblank | vblank;

	// The registered hs is the previous input, which gives the rising edge
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			line_odd_q <= 1'b0;
		end else if (hs && !vga_hs) begin
			line_odd_q <= !line_odd_q;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			vga_r  <= shade(r, blank, line_odd_q, cfg.scan_mode);
			vga_g  <= shade(g, blank, line_odd_q, cfg.scan_mode);
			vga_b  <= shade(b, blank, line_odd_q, cfg.scan_mode);
			vga_hs <= hs;
			vga_vs <= vs;
		end
	end

	a_blank_black: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(hblank || vblank) |=> (vga_r == '0 && vga_g == '0 && vga_b == '0));

endmodule

/* verilog/audio_mixer_dac.sv */
module audio_mixer_dac (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  arcade_pkg::sample_t audio_a,
	input  arcade_pkg::sample_t audio_b,
	shell_cfg_if.dp             cfg,
	output logic                audio_out
);

	arcade_pkg::mix_t mix_next;
	arcade_pkg::mix_t mix_q;
	logic [11:0]      acc_q;

	// Channel B is four times louder than channel A
	assign mix_next = {1'b0, audio_b, 2'b00} + {3'b000, audio_a};

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			mix_q <= '0;
		end else if (cfg.mute) begin
			mix_q <= '0;
		end else begin
			mix_q <= mix_next;
		end
	end

	// ==============================
	// First-order sigma-delta
	// ==============================

	// The carry out of the 11-bit sum is the DAC bit, so its density
	// over 2048 cycles tracks the mix value
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc_q <= '0;
		end else begin
			acc_q <= {1'b0, acc_q[10:0]} + {1'b0, mix_q};
		end
	end

	assign audio_out = acc_q[11];

	a_mix_range: assert property (@(posedge clk_sys) disable iff (!rst_n)
		mix_q <= 11'd1275);

endmodule

/* verilog/control_mapper.sv */
module control_mapper (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  arcade_pkg::kbjoy_t      kbjoy,
	input  arcade_pkg::joy_t        joystick_0,
	input  arcade_pkg::joy_t        joystick_1,
	shell_cfg_if.dp                 cfg,
	output arcade_pkg::player_ctl_t p1_ctl,
	output arcade_pkg::player_ctl_t p2_ctl
);

	logic right_in, left_in, down_in, up_in, fire_in;
	logic m_right, m_left, m_down, m_up;

	// Keyboard and both joysticks share every direction
	assign right_in = kbjoy[4] | joystick_0[0] | joystick_1[0];
	assign left_in  = kbjoy[5] | joystick_0[1] | joystick_1[1];
	assign down_in  = kbjoy[6] | joystick_0[2] | joystick_1[2];
	assign up_in    = kbjoy[7] | joystick_0[3] | joystick_1[3];
	assign fire_in  = kbjoy[0] | joystick_0[4] | joystick_1[4];

	// An upright cabinet turns the monitor a quarter turn,
	// so the stick has to turn with it
	assign m_up    = cfg.upright ? right_in : up_in;
	assign m_down  = cfg.upright ? left_in  : down_in;
	assign m_left  = cfg.upright ? down_in  : left_in;
	assign m_right = cfg.upright ? up_in    : right_in;

	// Word layout is {0, coin, start, fire, up, down, left, right}
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			p1_ctl <= '0;
			p2_ctl <= '0;
		end else begin
			// Player 1 steers sideways and owns the coin slot
			p1_ctl <= {1'b0, kbjoy[3], kbjoy[1], fire_in, 2'b00, m_left, m_right};
			// Player 2 steers up and down
			p2_ctl <= {1'b0, 1'b0, kbjoy[2], fire_in, m_up, m_down, 2'b00};
		end
	end

endmodule

/* verilog/wb_config_regs.sv */
module wb_config_regs #(
	parameter arcade_pkg::wb_data_t CORE_ID = 32'h424c4b48
) (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  arcade_pkg::wb_adr_t     wb_adr,
	input  arcade_pkg::wb_data_t    wb_dat_w,
	output arcade_pkg::wb_data_t    wb_dat_r,
	output logic                    wb_ack,
	input  arcade_pkg::player_ctl_t p1_ctl,
	input  arcade_pkg::player_ctl_t p2_ctl,
	shell_cfg_if.ctrl               cfg
);

	arcade_pkg::wb_state_t            state_q;
	logic [arcade_pkg::SETTINGS_W-1:0] settings_q;
	logic [1:0]                        scan_field;

	// ==============================
	// Bus sequencing
	// ==============================

	// A request is taken in idle, then acknowledged one edge later.
	// While the ack is out the master may still hold stb, so idle
	// ignores the request in that cycle
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state_q    <= arcade_pkg::wb_idle;
			wb_ack     <= 1'b0;
			settings_q <= '0;
		end else begin
			case (state_q)
				arcade_pkg::wb_idle: begin
					wb_ack <= 1'b0;
					if (wb_cyc && wb_stb && !wb_ack) begin
						state_q <= arcade_pkg::wb_ack;
					end
				end
				arcade_pkg::wb_ack: begin
					state_q <= arcade_pkg::wb_idle;
					// An abandoned cycle gets no ack
					wb_ack  <= wb_cyc && wb_stb;
					if (wb_cyc && wb_stb && wb_we && wb_adr == arcade_pkg::ADR_SETTINGS) begin
						settings_q <= wb_dat_w[arcade_pkg::SETTINGS_W-1:0];
					end
				end
				default: begin
					state_q <= arcade_pkg::wb_idle;
					wb_ack  <= 1'b0;
				end
			endcase
		end
	end

	// Read data is loaded on the same edge that raises the ack
	always_ff @(posedge clk_sys) begin
		if (state_q == arcade_pkg::wb_ack) begin
			case (wb_adr)
				arcade_pkg::ADR_SETTINGS: wb_dat_r <= arcade_pkg::wb_data_t'(settings_q);
				arcade_pkg::ADR_CORE_ID:  wb_dat_r <= CORE_ID;
				arcade_pkg::ADR_PLAYERS:  wb_dat_r <= {16'h0000, p2_ctl, p1_ctl};
				default:                  wb_dat_r <= '0;
			endcase
		end
	end

	// ==============================
	// Settings decode
	// ==============================
	assign scan_field     = settings_q[arcade_pkg::SET_SCAN_HI:arcade_pkg::SET_SCAN_LO];
	assign cfg.core_reset = settings_q[arcade_pkg::SET_CORE_RESET];
	assign cfg.upright    = settings_q[arcade_pkg::SET_UPRIGHT];
	assign cfg.mute       = settings_q[arcade_pkg::SET_MUTE];

	// Field value 1 selected hq2x on the original board, which is not built here
	always_comb begin
		case (scan_field)
			2'd2:    cfg.scan_mode = arcade_pkg::scan_dim25;
			2'd3:    cfg.scan_mode = arcade_pkg::scan_dim50;
			default: cfg.scan_mode = arcade_pkg::scan_off;
		endcase
	end

	a_ack_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		wb_ack |=> !wb_ack);

	// The request that idle accepted must precede the ack by two edges
	a_ack_after_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb, 2));

endmodule

/* verilog/shell_cfg_if.sv */
interface shell_cfg_if;

	// Operator settings, decoded from the settings register
	logic                   core_reset;
	logic                   upright;
	arcade_pkg::scan_mode_t scan_mode;
	logic                   mute;

	// The register block owns every setting
	modport ctrl (
		output core_reset,
		output upright,
		output scan_mode,
		output mute
	);

	// Datapath blocks only look at the settings
	modport dp (
		input upright,
		input scan_mode,
		input mute
	);

endinterface

/* verilog/arcade_pkg.sv */
package arcade_pkg;

	// ==============================
	// Vector types
	// ==============================
	typedef logic [7:0]  joy_t;
	typedef logic [9:0]  kbjoy_t;
	typedef logic [7:0]  player_ctl_t;
	typedef logic [7:0]  sample_t;
	typedef logic [10:0] mix_t;
	typedef logic [2:0]  core_color_t;
	typedef logic [5:0]  vga_color_t;
	typedef logic [1:0]  wb_adr_t;
	typedef logic [31:0] wb_data_t;

	// Settings field values 0 and 1 both decode to scan_off
	typedef enum logic [1:0] {
		scan_off   = 2'd0,
		scan_dim25 = 2'd1,
		scan_dim50 = 2'd2
	} scan_mode_t;

	typedef enum logic {
		wb_idle = 1'b0,
		wb_ack  = 1'b1
	} wb_state_t;

	// ==============================
	// Register map
	// ==============================
	parameter wb_adr_t ADR_SETTINGS = 2'd0;
	parameter wb_adr_t ADR_CORE_ID  = 2'd1;
	parameter wb_adr_t ADR_PLAYERS  = 2'd2;

	// Bit positions inside the settings register
	parameter int unsigned SET_CORE_RESET = 0;
	parameter int unsigned SET_UPRIGHT    = 2;
	parameter int unsigned SET_SCAN_LO    = 3;
	parameter int unsigned SET_SCAN_HI    = 4;
	parameter int unsigned SET_MUTE       = 5;
	parameter int unsigned SETTINGS_W     = 6;

endpackage
